// File: design/mmc1_pkg.sv
`default_nettype none

package mmc1_pkg;

	// Bus and memory address widths
	localparam int CPU_AW = 16;
	localparam int PPU_AW = 14;
	localparam int PRG_AW = 19;	// 512 KB of PRG ROM
	localparam int CHR_AW = 17;	// 128 KB of CHR ROM or RAM
	localparam int SRM_AW = 15;	// 32 KB of PRG-RAM
	localparam int MREG_W = 5;	// Every MMC1 register is five bits wide

	typedef logic [CPU_AW-1:0] cpu_addr_t;
	typedef logic [PPU_AW-1:0] ppu_addr_t;
	typedef logic [PRG_AW-1:0] prg_addr_t;
	typedef logic [CHR_AW-1:0] chr_addr_t;
	typedef logic [SRM_AW-1:0] srm_addr_t;
	typedef logic [MREG_W-1:0] mreg_t;

	// Register selected by CPU address bits 14:13 on the fifth write
	localparam logic [1:0] REG_CTRL = 2'd0;	// $8000-$9FFF
	localparam logic [1:0] REG_CHR0 = 2'd1;	// $A000-$BFFF
	localparam logic [1:0] REG_CHR1 = 2'd2;	// $C000-$DFFF
	localparam logic [1:0] REG_PRG  = 2'd3;	// $E000-$FFFF

	// The marker bit walks down as data bits enter from the top,
	// so the fifth write is the one that finds it in bit 0
	localparam mreg_t SHIFT_EMPTY = 5'b10000;

	// The power-up control value selects 4 KB CHR mode, PRG mode 3 and horizontal mirroring
	localparam mreg_t CTRL_RESET = 5'b11111;

	// Submapper that keeps CPU A14 as PRG A14 (32 KB boards wired without bank bit 0)
	localparam logic [3:0] SUB_PRG32 = 4'd5;

	// Mapper number of the MMC1 variant whose PRG-RAM cannot be disabled
	localparam logic [7:0] IDX_RAM_ALWAYS = 8'd155;

	// Save-state addresses 0 to 3 hold the registers themselves
	localparam logic [7:0] SST_SHIFT_ADDR = 8'd4;
	localparam logic [7:0] SST_IDX_ADDR   = 8'd127;

endpackage

`default_nettype wire

// File: design/mmc1_regs.sv
`default_nettype none
`timescale 1ns/1ns

module mmc1_regs
(
	input  wire                 m2,
	input  wire                 reg_rst,
	input  mmc1_pkg::cpu_addr_t cpu_addr,
	input  wire [7:0]           cpu_data,
	input  wire                 cpu_rw,
	input  wire                 sst_act,
	input  wire                 sst_we_reg,
	input  wire [7:0]           sst_addr,
	input  wire [4:0]           sst_dato,
	input  wire [7:0]           cfg_map_idx,
	output mmc1_pkg::mreg_t     r_ctrl,
	output mmc1_pkg::mreg_t     r_chr0,
	output mmc1_pkg::mreg_t     r_chr1,
	output mmc1_pkg::mreg_t     r_prg,
	output logic [7:0]          sst_di
);
	import mmc1_pkg::*;

	logic  wr_hist;	// Set when the previous m2 edge took a write
	mreg_t shift_q;
	mreg_t regs_q [4];

	logic  wr_stb;
	logic  wr_clr;
	logic  wr_commit;
	mreg_t shift_in;
	logic  sst_reg_sel;
	logic  sst_shift_sel;

	// The real chip only reacts to the first of two adjacent write cycles,
	// which is how it survives the double write of read-modify-write opcodes
	assign wr_stb    = cpu_addr[15] & ~cpu_rw & ~wr_hist;
	assign wr_clr    = wr_stb & cpu_data[7];
	assign wr_commit = wr_stb & ~cpu_data[7] & shift_q[0];
	assign shift_in  = {cpu_data[0], shift_q[4:1]};	// LSB first from the CPU

	assign sst_reg_sel   = (sst_addr[7:2] == 6'd0);
	assign sst_shift_sel = (sst_addr == SST_SHIFT_ADDR);

	always_ff @(posedge m2)
	begin
		if (reg_rst)
			wr_hist <= 1'b0;
		else
			wr_hist <= wr_stb;
	end

	always_ff @(posedge m2)
	begin
		if (reg_rst)
		begin
			regs_q[REG_CTRL] <= CTRL_RESET;
			regs_q[REG_CHR0] <= '0;
			regs_q[REG_CHR1] <= '0;
			regs_q[REG_PRG]  <= '0;	// Bit 4 low leaves PRG-RAM enabled
			shift_q          <= SHIFT_EMPTY;
		end
		else if (sst_act)
		begin
			// Save-state traffic owns the registers, CPU writes are dropped
			if (sst_we_reg && sst_reg_sel)
				regs_q[sst_addr[1:0]] <= sst_dato;
			if (sst_we_reg && sst_shift_sel)
				shift_q <= sst_dato;
		end
		else if (wr_clr)
		begin
			shift_q             <= SHIFT_EMPTY;
			regs_q[REG_CTRL][3:2] <= 2'b11;	// Back to PRG mode 3
		end
		else if (wr_stb)
		begin
			if (shift_q[0])
			begin
				regs_q[cpu_addr[14:13]] <= shift_in;
				shift_q                 <= SHIFT_EMPTY;
			end
			else
			begin
				shift_q <= shift_in;
			end
		end
	end

	assign r_ctrl = regs_q[REG_CTRL];
	assign r_chr0 = regs_q[REG_CHR0];
	assign r_chr1 = regs_q[REG_CHR1];
	assign r_prg  = regs_q[REG_PRG];

	always_comb
	begin
		if (sst_reg_sel)
			sst_di = {3'b000, regs_q[sst_addr[1:0]]};
		else if (sst_shift_sel)
			sst_di = {3'b000, shift_q};
		else if (sst_addr == SST_IDX_ADDR)
			sst_di = cfg_map_idx;	// Lets a loader check the state belongs to this mapper
		else
			sst_di = 8'hff;
	end

	// The marker bit must always be somewhere in the shift register
	a_shift_marker: assert property (@(posedge m2) disable iff (reg_rst)
		!sst_act |-> shift_q != '0)
		else $error("shift register lost its marker bit");

	// Fifth write hands the value over and restarts the serial load
	a_commit_empty: assert property (@(posedge m2) disable iff (reg_rst)
		wr_commit && !sst_act |=> shift_q == SHIFT_EMPTY)
		else $error("shift register not empty after a commit");

endmodule

`default_nettype wire

// File: design/mmc1_bank_map.sv
`default_nettype none
`timescale 1ns/1ns

module mmc1_bank_map
(
	input  mmc1_pkg::cpu_addr_t cpu_addr,
	input  wire                 cpu_rw,
	input  mmc1_pkg::ppu_addr_t ppu_addr,
	input  wire                 ppu_oe,
	input  wire                 ppu_we,
	input  wire                 cfg_chr_ram,
	input  wire [3:0]           cfg_map_sub,
	input  wire [7:0]           cfg_map_idx,
	input  mmc1_pkg::mreg_t     r_ctrl,
	input  mmc1_pkg::mreg_t     r_chr0,
	input  mmc1_pkg::mreg_t     r_chr1,
	input  mmc1_pkg::mreg_t     r_prg,
	input  wire [7:0]           prg_do,
	input  wire [7:0]           srm_do,
	output mmc1_pkg::prg_addr_t prg_addr,
	output logic                prg_ce,
	output logic                prg_oe,
	output mmc1_pkg::chr_addr_t chr_addr,
	output logic                chr_ce,
	output logic                chr_oe,
	output logic                chr_we,
	output mmc1_pkg::srm_addr_t srm_addr,
	output logic                srm_ce,
	output logic                srm_oe,
	output logic                srm_we,
	output logic                ciram_a10,
	output logic                ciram_ce,
	output logic                map_cpu_oe,
	output logic [7:0]          map_cpu_do
);
	import mmc1_pkg::*;

	logic       prg_mode;	// Clear selects 32 KB switching
	logic       chr_mode;	// Clear selects 8 KB switching
	logic       ram_on;
	logic [3:0] prg_bank;
	logic [4:0] chr_bank;
	logic       prg_a14;
	logic [4:0] chr_hi;
	logic [1:0] srm_bank;

	assign prg_mode = r_ctrl[3];
	assign chr_mode = r_ctrl[4];

	// In 16 KB mode control bit 2 names the fixed half, the other half follows r_prg
	always_comb
	begin
		if (!prg_mode)
			prg_bank = {r_prg[3:1], cpu_addr[14]};
		else if (r_ctrl[2] != cpu_addr[14])
			prg_bank = r_prg[3:0];
		else
			prg_bank = cpu_addr[14] ? 4'hf : 4'h0;
	end

	always_comb
	begin
		if (!chr_mode)
			chr_bank = {r_chr0[4:1], ppu_addr[12]};
		else if (ppu_addr[12])
			chr_bank = r_chr1;
		else
			chr_bank = r_chr0;
	end

	assign prg_a14 = (cfg_map_sub == SUB_PRG32) ? cpu_addr[14] : prg_bank[0];

	// SUROM style boards take the 256 KB PRG select from the live CHR bank
	assign prg_addr = {chr_bank[4], prg_bank[3:1], prg_a14, cpu_addr[13:0]};
	assign prg_ce   = cpu_addr[15];
	assign prg_oe   = cpu_rw;

	// With 8 KB of CHR RAM only bit 0 addresses CHR, bits 3:2 move to the PRG-RAM bank
	assign chr_hi   = cfg_chr_ram ? {4'b0000, chr_bank[0]} : chr_bank;
	assign srm_bank = cfg_chr_ram ? chr_bank[3:2] : 2'b00;

	assign chr_addr = {chr_hi, ppu_addr[11:0]};
	assign ciram_ce = ~ppu_addr[13];	// Pattern space is $0000-$1FFF
	assign chr_ce   = ciram_ce;
	assign chr_oe   = ~ppu_oe;
	assign chr_we   = cfg_chr_ram & ~ppu_we & ciram_ce;

	assign ram_on   = ~r_prg[4] | (cfg_map_idx == IDX_RAM_ALWAYS);
	assign srm_addr = {srm_bank, cpu_addr[12:0]};
	assign srm_ce   = (cpu_addr[15:13] == 3'b011) & ram_on;	// $6000-$7FFF window
	assign srm_oe   = cpu_rw;
	assign srm_we   = ~cpu_rw;

	// 0 and 1 are one-screen, 2 is vertical and 3 is horizontal
	always_comb
	begin
		case (r_ctrl[1:0])
			2'b00: ciram_a10 = 1'b0;
			2'b01: ciram_a10 = 1'b1;
			2'b10: ciram_a10 = ppu_addr[10];
			default: ciram_a10 = ppu_addr[11];
		endcase
	end

	assign map_cpu_oe = (srm_ce & srm_oe) | (prg_ce & prg_oe);
	assign map_cpu_do = srm_ce ? srm_do : prg_do;

	// The ROM and RAM windows come from separate address decodes
	always_comb
	begin
		assert (!(prg_ce && srm_ce))
			else $error("PRG ROM and PRG-RAM enabled together");
	end

endmodule

`default_nettype wire

// File: design/mmc1_top.sv
`default_nettype none
`timescale 1ns/1ns

module mmc1_top
(
	input  wire                 m2,
	input  wire                 reg_rst,
	input  mmc1_pkg::cpu_addr_t cpu_addr,
	input  wire [7:0]           cpu_data,
	input  wire                 cpu_rw,
	input  mmc1_pkg::ppu_addr_t ppu_addr,
	input  wire                 ppu_oe,
	input  wire                 ppu_we,
	input  wire                 cfg_chr_ram,
	input  wire [3:0]           cfg_map_sub,
	input  wire [7:0]           cfg_map_idx,
	input  wire                 sst_act,
	input  wire                 sst_we_reg,
	input  wire [7:0]           sst_addr,
	input  wire [4:0]           sst_dato,
	input  wire [7:0]           prg_do,
	input  wire [7:0]           srm_do,
	output mmc1_pkg::prg_addr_t prg_addr,
	output logic                prg_ce,
	output logic                prg_oe,
	output mmc1_pkg::chr_addr_t chr_addr,
	output logic                chr_ce,
	output logic                chr_oe,
	output logic                chr_we,
	output mmc1_pkg::srm_addr_t srm_addr,
	output logic                srm_ce,
	output logic                srm_oe,
	output logic                srm_we,
	output logic                ciram_a10,
	output logic                ciram_ce,
	output logic                map_cpu_oe,
	output logic [7:0]          map_cpu_do,
	output logic [7:0]          sst_di
);
	import mmc1_pkg::*;

	// Committed register values, the only state the bank mapper sees
	mreg_t r_ctrl;
	mreg_t r_chr0;
	mreg_t r_chr1;
	mreg_t r_prg;

	mmc1_regs u_regs
	(
		.m2          (m2),
		.reg_rst     (reg_rst),
		.cpu_addr    (cpu_addr),
		.cpu_data    (cpu_data),
		.cpu_rw      (cpu_rw),
		.sst_act     (sst_act),
		.sst_we_reg  (sst_we_reg),
		.sst_addr    (sst_addr),
		.sst_dato    (sst_dato),
		.cfg_map_idx (cfg_map_idx),
		.r_ctrl      (r_ctrl),
		.r_chr0      (r_chr0),
		.r_chr1      (r_chr1),
		.r_prg       (r_prg),
		.sst_di      (sst_di)
	);

	mmc1_bank_map u_bank_map
	(
		.cpu_addr    (cpu_addr),
		.cpu_rw      (cpu_rw),
		.ppu_addr    (ppu_addr),
		.ppu_oe      (ppu_oe),
		.ppu_we      (ppu_we),
		.cfg_chr_ram (cfg_chr_ram),
		.cfg_map_sub (cfg_map_sub),
		.cfg_map_idx (cfg_map_idx),
		.r_ctrl      (r_ctrl),
		.r_chr0      (r_chr0),
		.r_chr1      (r_chr1),
		.r_prg       (r_prg),
		.prg_do      (prg_do),
		.srm_do      (srm_do),
		.prg_addr    (prg_addr),
		.prg_ce      (prg_ce),
		.prg_oe      (prg_oe),
		.chr_addr    (chr_addr),
		.chr_ce      (chr_ce),
		.chr_oe      (chr_oe),
		.chr_we      (chr_we),
		.srm_addr    (srm_addr),
		.srm_ce      (srm_ce),
		.srm_oe      (srm_oe),
		.srm_we      (srm_we),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce),
		.map_cpu_oe  (map_cpu_oe),
		.map_cpu_do  (map_cpu_do)
	);

endmodule

`default_nettype wire

// File: testbench/tb_mmc1_model.svh
`ifndef TB_MMC1_MODEL_SVH
`define TB_MMC1_MODEL_SVH

// Shadow copy of the mapper state, stepped once per m2 cycle
mreg_t m_regs [4];
mreg_t m_shift;
logic  m_hist;	// Last cycle was a taken write

task automatic model_reset();
	m_regs[REG_CTRL] = CTRL_RESET;
	m_regs[REG_CHR0] = '0;
	m_regs[REG_CHR1] = '0;
	m_regs[REG_PRG]  = '0;
	m_shift          = SHIFT_EMPTY;
	m_hist           = 1'b0;
endtask

task automatic model_cycle(input cpu_addr_t ca, input logic [7:0] d, input logic rw);
	logic take;
	take   = ca[15] && !rw && !m_hist;
	m_hist = take;
	if (take && d[7])
	begin
		m_shift = SHIFT_EMPTY;
		m_regs[REG_CTRL][3:2] = 2'b11;
	end
	else if (take && m_shift[0])
	begin
		m_regs[ca[14:13]] = {d[0], m_shift[4:1]};	// Fifth bit completes the value
		m_shift = SHIFT_EMPTY;
	end
	else if (take)
		m_shift = {d[0], m_shift[4:1]};
endtask

task automatic model_sst_load(input logic [7:0] a, input mreg_t v);
	m_hist = 1'b0;
	if (a < 8'd4)
		m_regs[a[1:0]] = v;
	else if (a == SST_SHIFT_ADDR)
		m_shift = v;
endtask

// CHR bank in use for this PPU address
function automatic mreg_t sel_chr_bank(input ppu_addr_t pa);
	if (m_regs[REG_CTRL][4])
		return pa[12] ? m_regs[REG_CHR1] : m_regs[REG_CHR0];
	return {m_regs[REG_CHR0][4:1], pa[12]};
endfunction

function automatic prg_addr_t exp_prg_addr(input cpu_addr_t ca, input ppu_addr_t pa);
	logic [3:0] bank;
	mreg_t      p;
	mreg_t      sel;
	p = m_regs[REG_PRG];
	case (m_regs[REG_CTRL][3:2])
		2'b10: bank = ca[14] ? p[3:0] : 4'd0;	// First 16 KB fixed
		2'b11: bank = ca[14] ? 4'd15 : p[3:0];	// Last 16 KB fixed
		default: bank = {p[3:1], ca[14]};
	endcase
	if (cfg_map_sub == SUB_PRG32)
		bank[0] = ca[14];
	sel = sel_chr_bank(pa);
	return {sel[4], bank, ca[13:0]};
endfunction

function automatic chr_addr_t exp_chr_addr(input ppu_addr_t pa);
	mreg_t b;
	b = sel_chr_bank(pa);
	return cfg_chr_ram ? {4'b0000, b[0], pa[11:0]} : {b, pa[11:0]};
endfunction

function automatic srm_addr_t exp_srm_addr(input cpu_addr_t ca, input ppu_addr_t pa);
	mreg_t b;
	b = sel_chr_bank(pa);
	return {cfg_chr_ram ? b[3:2] : 2'b00, ca[12:0]};
endfunction

function automatic logic exp_a10(input ppu_addr_t pa);
	case (m_regs[REG_CTRL][1:0])
		2'b00: return 1'b0;
		2'b01: return 1'b1;
		2'b10: return pa[10];
		default: return pa[11];
	endcase
endfunction

function automatic logic [7:0] exp_sst(input logic [7:0] a);
	if (a < 8'd4)
		return {3'b000, m_regs[a[1:0]]};
	if (a == SST_SHIFT_ADDR)
		return {3'b000, m_shift};
	if (a == SST_IDX_ADDR)
		return cfg_map_idx;
	return 8'hff;
endfunction

`endif

// File: testbench/tb_mmc1.sv
`default_nettype none
`timescale 1ns/1ns

module tb_mmc1;
	import mmc1_pkg::*;

	localparam int MAX_CYCLES = 4000;	// Several times the length of the test sequence

	logic       m2;
	logic       reg_rst;
	cpu_addr_t  cpu_addr;
	logic [7:0] cpu_data;
	logic       cpu_rw;
	ppu_addr_t  ppu_addr;
	logic       ppu_oe;
	logic       ppu_we;
	logic       cfg_chr_ram;
	logic [3:0] cfg_map_sub;
	logic [7:0] cfg_map_idx;
	logic       sst_act;
	logic       sst_we_reg;
	logic [7:0] sst_addr;
	mreg_t      sst_dato;
	logic [7:0] prg_do;
	logic [7:0] srm_do;
	prg_addr_t  prg_addr;
	logic       prg_ce;
	logic       prg_oe;
	chr_addr_t  chr_addr;
	logic       chr_ce;
	logic       chr_oe;
	logic       chr_we;
	srm_addr_t  srm_addr;
	logic       srm_ce;
	logic       srm_oe;
	logic       srm_we;
	logic       ciram_a10;
	logic       ciram_ce;
	logic       map_cpu_oe;
	logic [7:0] map_cpu_do;
	logic [7:0] sst_di;

	// Expected outputs for the probe cycle in flight
	prg_addr_t  e_prg;
	chr_addr_t  e_chr;
	srm_addr_t  e_srm;
	logic       e_prg_ce;
	logic       e_prg_oe;
	logic       e_chr_ce;
	logic       e_chr_oe;
	logic       e_chr_we;
	logic       e_srm_ce;
	logic       e_srm_oe;
	logic       e_srm_we;
	logic       e_a10;
	logic       e_ciram_ce;
	logic       e_map_oe;
	logic [7:0] e_do;
	logic [7:0] e_sst;
	logic       probe_on;

	integer      seed = 12;
	logic [31:0] rnd;
	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          err_mark = 0;
	int          cyc = 0;

	`include "tb_mmc1_model.svh"

	mmc1_top UUT (.*);

	initial
	begin
		m2 = 1'b0;
		forever #5 m2 = ~m2;
	end

	always @(posedge m2)
	begin
		cyc++;
		if (cyc >= MAX_CYCLES)
		begin
			$display("Timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic report_err(input string name, input logic [31:0] e, input logic [31:0] a);
		err_cnt++;
		$display("[ERROR] %0t %s expected %h got %h", $time, name, e, a);
	endtask

	task automatic check_prg(input string name, input prg_addr_t e, input prg_addr_t a);
		chk_cnt++;
		if (a !== e) report_err(name, 32'(e), 32'(a));
	endtask

	task automatic check_chr(input string name, input chr_addr_t e, input chr_addr_t a);
		chk_cnt++;
		if (a !== e) report_err(name, 32'(e), 32'(a));
	endtask

	task automatic check_srm(input string name, input srm_addr_t e, input srm_addr_t a);
		chk_cnt++;
		if (a !== e) report_err(name, 32'(e), 32'(a));
	endtask

	task automatic check_bit(input string name, input logic e, input logic a);
		chk_cnt++;
		if (a !== e) report_err(name, 32'(e), 32'(a));
	endtask

	task automatic check_byte(input string name, input logic [7:0] e, input logic [7:0] a);
		chk_cnt++;
		if (a !== e) report_err(name, 32'(e), 32'(a));
	endtask

	// Probe cycles never write to $8000-$FFFF, so no register moves on the edge that samples them
	always @(posedge m2)
	begin
		if (probe_on)
		begin
			check_prg("prg_addr", e_prg, prg_addr);
			check_bit("prg_ce", e_prg_ce, prg_ce);
			check_bit("prg_oe", e_prg_oe, prg_oe);
			check_chr("chr_addr", e_chr, chr_addr);
			check_bit("chr_ce", e_chr_ce, chr_ce);
			check_bit("chr_oe", e_chr_oe, chr_oe);
			check_bit("chr_we", e_chr_we, chr_we);
			check_srm("srm_addr", e_srm, srm_addr);
			check_bit("srm_ce", e_srm_ce, srm_ce);
			check_bit("srm_oe", e_srm_oe, srm_oe);
			check_bit("srm_we", e_srm_we, srm_we);
			check_bit("ciram_a10", e_a10, ciram_a10);
			check_bit("ciram_ce", e_ciram_ce, ciram_ce);
			check_bit("map_cpu_oe", e_map_oe, map_cpu_oe);
			check_byte("map_cpu_do", e_do, map_cpu_do);
			check_byte("sst_di", e_sst, sst_di);
		end
	end

	task automatic bus_cycle(input cpu_addr_t ca, input logic [7:0] d, input logic rw);
		@(negedge m2);
		probe_on   = 1'b0;
		cpu_addr   = ca;
		cpu_data   = d;
		cpu_rw     = rw;
		sst_act    = 1'b0;
		sst_we_reg = 1'b0;
		model_cycle(ca, d, rw);
	endtask

	task automatic idle_cycle();
		bus_cycle(16'h0000, 8'h00, 1'b1);
	endtask

	task automatic write_reg_raw(input cpu_addr_t ca, input logic [7:0] d);
		bus_cycle(ca, d, 1'b0);
	endtask

	task automatic write_serial(input cpu_addr_t ca, input mreg_t v);
		for (int i = 0; i < 5; i++)
		begin
			write_reg_raw(ca, {7'b0000000, v[i]});
			idle_cycle();
		end
	endtask

	task automatic sst_write(input logic [7:0] a, input mreg_t v);
		@(negedge m2);
		probe_on   = 1'b0;
		cpu_addr   = '0;
		cpu_rw     = 1'b1;
		sst_act    = 1'b1;
		sst_we_reg = 1'b1;
		sst_addr   = a;
		sst_dato   = v;
		model_sst_load(a, v);
	endtask

	task automatic probe(input cpu_addr_t ca, input ppu_addr_t pa, input logic pwe_n,
		input logic [7:0] sa);
		logic [31:0] r;
		logic        rw;
		logic        ram_hit;
		r  = $random(seed);
		rw = ca[15] | r[8];	// Below $8000 a probe may also be a CPU write
		bus_cycle(ca, 8'h00, rw);
		ppu_addr = pa;
		ppu_oe   = ~pwe_n;
		ppu_we   = pwe_n;
		sst_addr = sa;
		prg_do   = r[7:0];
		srm_do   = ~r[7:0];
		ram_hit  = (ca[15:13] == 3'b011)
			&& (!m_regs[REG_PRG][4] || cfg_map_idx == IDX_RAM_ALWAYS);
		e_prg      = exp_prg_addr(ca, pa);
		e_prg_ce   = ca[15];	// PRG ROM fills $8000-$FFFF
		e_prg_oe   = rw;
		e_chr      = exp_chr_addr(pa);
		e_chr_ce   = !pa[13];
		e_chr_oe   = pwe_n;	// The PPU reads whenever it does not write
		e_chr_we   = cfg_chr_ram && !pwe_n && !pa[13];
		e_srm      = exp_srm_addr(ca, pa);
		e_srm_ce   = ram_hit;
		e_srm_oe   = rw;
		e_srm_we   = !rw;
		e_a10      = exp_a10(pa);
		e_ciram_ce = !pa[13];	// Active low, so CIRAM is selected in the nametable space
		e_map_oe   = rw && (ca[15] || ram_hit);
		e_do       = ram_hit ? ~r[7:0] : r[7:0];
		e_sst      = exp_sst(sa);
		probe_on   = 1'b1;
	endtask

	task automatic test_done(input string name);
		$display("test %s done, %0d errors", name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	initial
	begin
		int m;
		int i;
		int k;
		cpu_addr    = '0;
		cpu_data    = '0;
		cpu_rw      = 1'b1;
		ppu_addr    = '0;
		ppu_oe      = 1'b1;
		ppu_we      = 1'b1;
		cfg_chr_ram = 1'b0;
		cfg_map_sub = 4'd0;
		cfg_map_idx = 8'd1;
		sst_act     = 1'b0;
		sst_we_reg  = 1'b0;
		sst_addr    = '0;
		sst_dato    = '0;
		prg_do      = '0;
		srm_do      = '0;
		probe_on    = 1'b0;
		reg_rst     = 1'b1;
		model_reset();
		repeat (5) @(negedge m2);
		reg_rst = 1'b0;

		for (m = 0; m < 5; m++)
		begin
			cfg_map_sub = (m == 4) ? SUB_PRG32 : 4'd0;	// Last pass is mode 3 on submapper 5
			rnd = $random(seed);
			write_serial(16'h8000, {rnd[4], ((m == 4) ? 2'b11 : m[1:0]), rnd[1:0]});
			write_serial(16'hA000, rnd[12:8]);
			write_serial(16'hE000, {1'b0, rnd[19:16]});
			for (i = 8; i < 16; i++)
			begin
				rnd = $random(seed);
				probe({i[3:0], rnd[11:0]}, {1'b0, rnd[24:12]}, 1'b1, 8'd3);
			end
			idle_cycle();	// Last probe is compared before the board setup changes
		end
		cfg_map_sub = 4'd0;
		test_done("prg_banking");

		write_serial(16'h8000, 5'b00010);	// Mode 0 so the forced mode 3 shows
		write_reg_raw(16'hE000, 8'h01);
		idle_cycle();
		write_reg_raw(16'hE000, 8'h00);
		probe(16'hC123, 14'h0000, 1'b1, SST_SHIFT_ADDR);
		write_reg_raw(16'hE000, 8'h80);
		probe(16'hC123, 14'h0000, 1'b1, SST_SHIFT_ADDR);
		probe(16'h8456, 14'h0000, 1'b1, 8'd0);
		write_serial(16'hE000, 5'b00110);
		probe(16'h9abc, 14'h1000, 1'b1, 8'd3);
		probe(16'hdef0, 14'h0000, 1'b1, SST_SHIFT_ADDR);
		idle_cycle();
		test_done("clear_write");

		write_reg_raw(16'h8000, 8'h01);
		write_reg_raw(16'h8000, 8'h00);	// Dummy write of a read-modify-write
		probe(16'h8000, 14'h0000, 1'b1, SST_SHIFT_ADDR);
		write_reg_raw(16'h8000, 8'h00);
		write_reg_raw(16'h8000, 8'h01);
		write_reg_raw(16'h8000, 8'h01);
		probe(16'h8000, 14'h0000, 1'b1, SST_SHIFT_ADDR);
		write_reg_raw(16'h8000, 8'h80);
		test_done("consecutive");

		for (k = 0; k < 4; k++)
		begin
			cfg_chr_ram = k[1];
			rnd = $random(seed);
			write_serial(16'h8000, {k[0], 2'b11, rnd[1:0]});
			write_serial(16'hA000, rnd[8:4]);
			write_serial(16'hC000, rnd[16:12]);
			for (i = 0; i < 8; i++)
			begin
				rnd = $random(seed);
				probe({3'b011, rnd[12:0]}, {1'b0, i[2:0], rnd[22:13]}, rnd[23], 8'd1);
			end
			idle_cycle();
		end
		test_done("chr_banking");

		cfg_chr_ram = 1'b1;
		for (k = 0; k < 4; k++)
		begin
			write_serial(16'h8000, {3'b011, k[1:0]});
			for (i = 0; i < 4; i++)
			begin
				rnd = $random(seed);
				probe({1'b1, rnd[14:0]}, {2'b10, rnd[27:16]}, 1'b1, 8'd0);
			end
		end
		for (k = 0; k < 4; k++)
		begin
			cfg_map_idx = k[1] ? IDX_RAM_ALWAYS : 8'd1;
			rnd = $random(seed);
			write_serial(16'hE000, {k[0], rnd[3:0]});
			for (i = 0; i < 6; i++)
			begin
				rnd = $random(seed);
				probe(i[0] ? {1'b1, rnd[14:0]} : {3'b011, rnd[12:0]}, {1'b0, rnd[28:16]},
					1'b1, 8'd2);
			end
			idle_cycle();
		end
		cfg_map_idx = 8'd1;
		test_done("mirror_prg_ram");

		for (k = 0; k < 5; k++)
		begin
			rnd = $random(seed);
			sst_write(k[7:0], (k == 4) ? (rnd[4:0] | 5'b00001) : rnd[4:0]);
		end
		idle_cycle();
		for (k = 0; k < 7; k++)
		begin
			rnd = $random(seed);
			probe({1'b1, rnd[14:0]}, {1'b0, rnd[28:16]}, 1'b1,
				(k < 5) ? k[7:0] : ((k == 5) ? SST_IDX_ADDR : 8'd9));
		end
		idle_cycle();	// The last probe is compared on this edge
		test_done("save_state");

		$display("tests=6 checks=%0d errors=%0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+testbench
design/mmc1_pkg.sv
design/mmc1_regs.sv
design/mmc1_bank_map.sv
design/mmc1_top.sv
testbench/tb_mmc1.sv

// File: run_sim.sh
#!/bin/sh
# Builds the MMC1 testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_mmc1 -f src.f -Mdir obj_dir -o tb_mmc1_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mmc1_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
